/* Makefile */
# Verilator simulation of the ADC SPI capture subsystem
# A failing run ends in $fatal, so the simulator exits with an error status

.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 --top-module system_tb -f compile.f
	./obj_dir/Vsystem_tb

clean:
	rm -rf obj_dir

/* compile.f */
logic/adc_spi_pkg.sv
logic/adc_ctrl_if.sv
logic/adc_spi_regs.sv
logic/adc_spi_engine.sv
logic/adc_spi_top.sv
sim/adc_model.sv
sim/test_program.sv
sim/system_tb.sv

/* logic/adc_ctrl_if.sv */
// Control interface between the register block and the capture engine
// Carries the start request, frame settings and the captured sample
`timescale 1ns/1ps

interface adc_ctrl_if;
    import adc_spi_pkg::*;

    // One-cycle conversion request from the register block
    logic                   start;
    // Levels that the engine latches at start
    logic [CLK_DIV_W-1:0]   clk_div;
    logic [SAMPLE_BITS-1:0] cmd;
    // Engine is between start and done
    logic                   busy;
    // One-cycle pulse when the sample is complete
    logic                   done;
    adc_word_u              sample;

    // The register side owns the settings and watches the engine
    modport regs (
        output start,
        output clk_div,
        output cmd,
        input  busy,
        input  done,
        input  sample
    );

    modport engine (
        input  start,
        input  clk_div,
        input  cmd,
        output busy,
        output done,
        output sample
    );

endinterface

/* logic/adc_spi_engine.sv */
// ADC SPI capture engine
// Pulses cnvst, waits for busy to fall and runs one dual-lane SPI frame
`timescale 1ns/1ps

module adc_spi_engine (
    input  logic       spi_clk,
    input  logic       arst_n,
    input  logic       busy,
    input  logic [1:0] sdi,
    output logic       cnvst,
    output logic       cs,
    output logic       sclk,
    output logic       sdo,
    adc_ctrl_if.engine ctrl
);
    import adc_spi_pkg::*;

    // ******************************
    // State
    // ******************************
    logic [STATE_W-1:0]     state;
    logic [CLK_DIV_W-1:0]   clk_div_q;
    logic [CLK_DIV_W-1:0]   div_cnt;
    logic [BIT_CNT_W-1:0]   bit_cnt;
    logic                   done_q;

    // Frame payload
    logic [SAMPLE_BITS-1:0] cmd_sr;
    logic [SAMPLE_BITS-1:0] lane_a_sr;
    logic [SAMPLE_BITS-1:0] lane_b_sr;
    adc_word_u              sample_w;

    // Edge strobes
    logic                   half_end;
    logic                   load_evt;
    logic                   rise_evt;
    logic                   fall_evt;

    // A half period ends after clk_div+1 cycles
    assign half_end = (div_cnt == clk_div_q);

    // A start is accepted only from idle, so a start during a conversion is lost
    assign load_evt = (state == ST_IDLE) & ctrl.start;

    // sclk toggles at the end of each half period inside the frame
    assign rise_evt = (state == ST_FRAME) & half_end & ~sclk;
    assign fall_evt = (state == ST_FRAME) & half_end & sclk;

    // ******************************
    // Sequencer
    // ******************************
    always_ff @(posedge spi_clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ST_IDLE;
            clk_div_q <= CLK_DIV_RESET;
            div_cnt   <= '0;
            bit_cnt   <= '0;
            done_q    <= 1'b0;
            cnvst     <= 1'b0;
            cs        <= 1'b1;
            sclk      <= 1'b0;
            sdo       <= 1'b0;
        end else begin
            // cnvst and done are single-cycle pulses
            cnvst  <= 1'b0;
            done_q <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (load_evt) begin
                        // Later writes to the divider do not reach this frame
                        clk_div_q <= ctrl.clk_div;
                        cnvst     <= 1'b1;
                        state     <= ST_CONVERT;
                    end
                end
                ST_CONVERT: begin
                    // cnvst is high during this cycle
                    state <= ST_WAIT_BUSY;
                end
                ST_WAIT_BUSY: begin
                    if (!busy) begin
                        // The first command bit is on sdo before the first rising edge
                        cs      <= 1'b0;
                        sdo     <= cmd_sr[SAMPLE_BITS-1];
                        div_cnt <= '0;
                        bit_cnt <= '0;
                        state   <= ST_FRAME;
                    end
                end
                ST_FRAME: begin
                    if (half_end) begin
                        div_cnt <= '0;
                        sclk    <= ~sclk;
                        if (sclk) begin
                            // Falling edge
                            if (bit_cnt == BIT_CNT_W'(SAMPLE_BITS - 1)) begin
                                sdo   <= 1'b0;
                                state <= ST_FINISH;
                            end else begin
                                bit_cnt <= bit_cnt + BIT_CNT_W'(1);
                                sdo     <= cmd_sr[SAMPLE_BITS-2];
                            end
                        end
                    end else begin
                        div_cnt <= div_cnt + CLK_DIV_W'(1);
                    end
                end
                ST_FINISH: begin
                    // cs stays low for one more half period after the last fall
                    if (half_end) begin
                        cs     <= 1'b1;
                        done_q <= 1'b1;
                        state  <= ST_IDLE;
                    end else begin
                        div_cnt <= div_cnt + CLK_DIV_W'(1);
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // ******************************
    // Shift registers
    // ******************************
    always_ff @(posedge spi_clk) begin
        // The command is latched at start and shifted out MSB first
        if (load_evt) begin
            cmd_sr <= ctrl.cmd;
        end else if (fall_evt) begin
            cmd_sr <= {cmd_sr[SAMPLE_BITS-2:0], 1'b0};
        end

        // Both lanes are sampled as sclk goes high
        if (rise_evt) begin
            lane_a_sr <= {lane_a_sr[SAMPLE_BITS-2:0], sdi[0]};
            lane_b_sr <= {lane_b_sr[SAMPLE_BITS-2:0], sdi[1]};
        end
    end

    // The lanes are complete and stable by the time done pulses
    always_comb begin
        sample_w.lanes.ch_b = lane_b_sr;
        sample_w.lanes.ch_a = lane_a_sr;
    end

    assign ctrl.sample = sample_w;
    assign ctrl.done   = done_q;
    // Busy covers everything from the cycle after start up to done
    assign ctrl.busy   = (state != ST_IDLE);

endmodule

/* logic/adc_spi_pkg.sv */
// ADC SPI capture package
// Holds the widths, register map, bit positions, FSM encodings and sample types
package adc_spi_pkg;

    // ******************************
    // Widths
    // ******************************
    // One lane result per sdi line
    localparam int SAMPLE_BITS = 16;
    localparam int CLK_DIV_W   = 8;
    localparam int BIT_CNT_W   = $clog2(SAMPLE_BITS);
    localparam int STATE_W     = 3;

    // The divider comes out of reset at 1, so sclk runs at spi_clk/4
    localparam logic [CLK_DIV_W-1:0] CLK_DIV_RESET = 8'd1;

    typedef logic [3:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // Lane b sits in the upper half of the word
    typedef struct packed {
        logic [SAMPLE_BITS-1:0] ch_b;
        logic [SAMPLE_BITS-1:0] ch_a;
    } adc_lanes_t;

    // The engine fills the lanes and software sees the raw word
    typedef union packed {
        apb_data_t  raw;
        adc_lanes_t lanes;
    } adc_word_u;

    // ******************************
    // Register map
    // ******************************
    localparam apb_addr_t ADDR_CTRL   = 4'h0;
    localparam apb_addr_t ADDR_CMD    = 4'h4;
    localparam apb_addr_t ADDR_STATUS = 4'h8;
    localparam apb_addr_t ADDR_DATA   = 4'hC;

    localparam int CTRL_START   = 0;
    localparam int CTRL_IRQ_EN  = 1;
    localparam int CTRL_DIV_LSB = 8;
    localparam int CTRL_DIV_MSB = 15;
    localparam int STAT_BUSY    = 0;
    localparam int STAT_DONE    = 1;

    // Capture FSM states
    localparam logic [STATE_W-1:0] ST_IDLE      = 3'd0;
    localparam logic [STATE_W-1:0] ST_CONVERT   = 3'd1;
    localparam logic [STATE_W-1:0] ST_WAIT_BUSY = 3'd2;
    localparam logic [STATE_W-1:0] ST_FRAME     = 3'd3;
    localparam logic [STATE_W-1:0] ST_FINISH    = 3'd4;

endpackage

/* logic/adc_spi_regs.sv */
// ADC SPI register block
// APB3 slave with control, command, status and sample registers plus irq
`timescale 1ns/1ps

module adc_spi_regs (
    input  logic                  spi_clk,
    input  logic                  arst_n,
    input  adc_spi_pkg::apb_addr_t paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  adc_spi_pkg::apb_data_t pwdata,
    output adc_spi_pkg::apb_data_t prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic                  irq,
    adc_ctrl_if.regs              ctrl
);
    import adc_spi_pkg::*;

    // ******************************
    // APB decode
    // ******************************
    logic                   access;
    logic                   addr_ok;
    logic                   bad_access;
    logic                   wr_en;
    logic                   wr_ctrl;
    logic                   wr_cmd;
    logic                   wr_status;

    // Register state
    logic                   start_q;
    logic                   irq_en_q;
    logic [CLK_DIV_W-1:0]   clk_div_q;
    logic [SAMPLE_BITS-1:0] cmd_q;
    logic                   done_q;
    apb_data_t              data_q;

    // The second phase of a transfer is the only one that acts
    assign access = psel & penable;

    // Only the four word addresses are mapped
    assign addr_ok = (paddr == ADDR_CTRL) || (paddr == ADDR_CMD) ||
                     (paddr == ADDR_STATUS) || (paddr == ADDR_DATA);

    // DATA is read only and a write to it is refused
    assign bad_access = !addr_ok || (pwrite && (paddr == ADDR_DATA));

    // There are no wait states in this slave
    assign pready  = 1'b1;
    assign pslverr = access & bad_access;

    // A refused access changes no register
    assign wr_en     = access & pwrite & ~bad_access;
    assign wr_ctrl   = wr_en & (paddr == ADDR_CTRL);
    assign wr_cmd    = wr_en & (paddr == ADDR_CMD);
    assign wr_status = wr_en & (paddr == ADDR_STATUS);

    // ******************************
    // Registers
    // ******************************
    always_ff @(posedge spi_clk or negedge arst_n) begin
        if (!arst_n) begin
            start_q   <= 1'b0;
            irq_en_q  <= 1'b0;
            clk_div_q <= CLK_DIV_RESET;
            cmd_q     <= '0;
            done_q    <= 1'b0;
            data_q    <= '0;
        end else begin
            // Start is a pulse in the cycle after the CTRL write
            start_q <= wr_ctrl & pwdata[CTRL_START];

            if (wr_ctrl) begin
                irq_en_q  <= pwdata[CTRL_IRQ_EN];
                clk_div_q <= pwdata[CTRL_DIV_MSB:CTRL_DIV_LSB];
            end

            if (wr_cmd) begin
                cmd_q <= pwdata[SAMPLE_BITS-1:0];
            end

            // A new done wins over a clear in the same cycle so no sample goes unseen
            if (ctrl.done) begin
                done_q <= 1'b1;
            end else if (wr_status && pwdata[STAT_DONE]) begin
                done_q <= 1'b0;
            end

            // The sample word is taken in the cycle the engine reports it
            if (ctrl.done) begin
                data_q <= ctrl.sample.raw;
            end
        end
    end

    // Settings go straight to the engine, which latches them at start
    assign ctrl.start   = start_q;
    assign ctrl.clk_div = clk_div_q;
    assign ctrl.cmd     = cmd_q;

    assign irq = done_q & irq_en_q;

    // ******************************
    // Read mux
    // ******************************
    always_comb begin
        prdata = '0;
        case (paddr)
            ADDR_CTRL: begin
                // The start bit always reads back as zero
                prdata[CTRL_IRQ_EN]               = irq_en_q;
                prdata[CTRL_DIV_MSB:CTRL_DIV_LSB] = clk_div_q;
            end
            ADDR_CMD: begin
                prdata[SAMPLE_BITS-1:0] = cmd_q;
            end
            ADDR_STATUS: begin
                // Busy is the live engine state
                prdata[STAT_BUSY] = ctrl.busy;
                prdata[STAT_DONE] = done_q;
            end
            ADDR_DATA: begin
                prdata = data_q;
            end
            default: begin
                prdata = '0;
            end
        endcase
    end

endmodule

/* logic/adc_spi_top.sv */
// ADC SPI capture subsystem top level
// Joins the APB register block and the capture engine through the control interface
`timescale 1ns/1ps

module adc_spi_top (
    // Clock and reset
    input  logic                   spi_clk,
    input  logic                   arst_n,

    // APB slave
    input  adc_spi_pkg::apb_addr_t paddr,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  adc_spi_pkg::apb_data_t pwdata,
    output adc_spi_pkg::apb_data_t prdata,
    output logic                   pready,
    output logic                   pslverr,
    output logic                   irq,

    // ADC pins
    output logic                   cnvst,
    output logic                   cs,
    output logic                   sclk,
    output logic                   sdo,
    input  logic                   busy,
    input  logic [1:0]             sdi
);

    // Settings, handshake and sample between the two blocks
    adc_ctrl_if ctrl_if ();

    // ******************************
    // Register block
    // ******************************
    adc_spi_regs u_regs (
        .spi_clk (spi_clk),
        .arst_n  (arst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .irq     (irq),
        .ctrl    (ctrl_if.regs)
    );

    // ******************************
    // Capture engine
    // ******************************
    adc_spi_engine u_engine (
        .spi_clk (spi_clk),
        .arst_n  (arst_n),
        .busy    (busy),
        .sdi     (sdi),
        .cnvst   (cnvst),
        .cs      (cs),
        .sclk    (sclk),
        .sdo     (sdo),
        .ctrl    (ctrl_if.engine)
    );

endmodule

/* sim/adc_model.sv */
// Behavioral dual-lane serial ADC
// Counts conversions, records the command on sdo and answers each frame on both sdi lanes
`timescale 1ns/1ps

module adc_model (
    input  logic        cnvst,
    input  logic        cs,
    input  logic        sclk,
    input  logic        sdo,
    output logic [1:0]  sdi,
    output logic [15:0] conv_count,
    output logic [15:0] sdo_word
);

    // Conversion number, 1 for the first cnvst pulse
    logic [15:0] count_q = '0;
    // Command of the previous frame, zero before any frame
    logic [15:0] prev_cmd;
    logic [15:0] lane_a;
    logic [15:0] rx_word;

    always @(posedge cnvst) begin
        count_q = count_q + 16'd1;
    end

    assign conv_count = count_q;

    // ******************************
    // Frame service
    // ******************************
    // One pass of the loop serves one frame
    initial begin : serve_frames
        int i;
        sdi      = 2'b00;
        sdo_word = '0;
        prev_cmd = '0;
        forever begin
            @(negedge cs);
            // Lane a carries the old command byte above the conversion count
            lane_a = {prev_cmd[7:0], count_q[7:0]};
            for (i = 15; i >= 0; i--) begin
                // The first bit is out as cs falls, the rest after each falling sclk
                sdi = {~lane_a[i], lane_a[i]};
                @(posedge sclk);
                rx_word[i] = sdo;
                @(negedge sclk);
            end
            sdi = 2'b00;
            @(posedge cs);
            sdo_word = rx_word;
            prev_cmd = rx_word;
        end
    end

endmodule

/* sim/system_tb.sv */
// ADC capture system testbench
// Clock, reset, DUT, ADC model and test program, and the final verdict
`timescale 1ns/1ps

module system_tb;
    import adc_spi_pkg::*;

    logic        spi_clk;
    logic        arst_n;
    apb_addr_t   paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    apb_data_t   pwdata;
    apb_data_t   prdata;
    logic        pready;
    logic        pslverr;
    logic        irq;
    logic        cnvst;
    logic        cs;
    logic        sclk;
    logic        sdo;
    logic        busy;
    logic [1:0]  sdi;
    logic [15:0] conv_count;
    logic [15:0] sdo_word;
    logic        run_done;
    logic        run_failed;

    // 40 ns period
    initial begin
        spi_clk = 1'b0;
        forever begin
            #20 spi_clk = ~spi_clk;
        end
    end

    // Reset for three cycles, released just after an edge
    initial begin
        arst_n = 1'b0;
        repeat (3) @(posedge spi_clk);
        #1 arst_n = 1'b1;
    end

    // The ADC reports busy exactly while cnvst is high
    assign busy = cnvst;

    adc_spi_top dut0 (
        .spi_clk (spi_clk),
        .arst_n  (arst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .irq     (irq),
        .cnvst   (cnvst),
        .cs      (cs),
        .sclk    (sclk),
        .sdo     (sdo),
        .busy    (busy),
        .sdi     (sdi)
    );

    adc_model u_adc (
        .cnvst      (cnvst),
        .cs         (cs),
        .sclk       (sclk),
        .sdo        (sdo),
        .sdi        (sdi),
        .conv_count (conv_count),
        .sdo_word   (sdo_word)
    );

    test_program u_test (
        .spi_clk    (spi_clk),
        .arst_n     (arst_n),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .irq        (irq),
        .cs         (cs),
        .conv_count (conv_count),
        .sdo_word   (sdo_word),
        .run_done   (run_done),
        .run_failed (run_failed)
    );

    // ******************************
    // Verdict
    // ******************************
    initial begin : verdict
        int cycles;
        cycles = 0;
        while (run_done !== 1'b1 && run_failed !== 1'b1 && cycles < 20000) begin
            @(posedge spi_clk);
            cycles++;
        end
        if (run_failed === 1'b1 || run_done !== 1'b1) begin
            if (run_failed !== 1'b1) begin
                $display("The run did not finish within 20000 cycles");
            end
            $display("TEST FAILED");
            $fatal(1, "Simulation stopped on a failure");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

/* sim/test_program.sv */
// ADC capture test program
// Drives APB, predicts every sample and checks registers, irq and the ADC side
`timescale 1ns/1ps

module test_program (
    input  logic                   spi_clk,
    input  logic                   arst_n,
    output adc_spi_pkg::apb_addr_t paddr,
    output logic                   psel,
    output logic                   penable,
    output logic                   pwrite,
    output adc_spi_pkg::apb_data_t pwdata,
    input  adc_spi_pkg::apb_data_t prdata,
    input  logic                   pready,
    input  logic                   pslverr,
    input  logic                   irq,
    input  logic                   cs,
    input  logic [15:0]            conv_count,
    input  logic [15:0]            sdo_word,
    output logic                   run_done,
    output logic                   run_failed
);
    import adc_spi_pkg::*;

    int                     seed;
    // Conversions started so far and the command of the last one
    int                     conv_total;
    logic [SAMPLE_BITS-1:0] prev_cmd;

    // ******************************
    // Failure and compare tasks
    // ******************************
    // The top sees the flag and ends the run, this process just parks
    task automatic stop_on_failure();
        run_failed = 1'b1;
        forever begin
            @(posedge spi_clk);
        end
    endtask

    task automatic check_word(input string name, input apb_data_t exp, input apb_data_t act);
        if (exp !== act) begin
            $display("error %s: expected %h, actual %h", name, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_sample(input string name, input adc_word_u exp, input adc_word_u act);
        if (exp.raw !== act.raw) begin
            $display("error %s: expected %h (ch_b %h ch_a %h), actual %h (ch_b %h ch_a %h)",
                     name, exp.raw, exp.lanes.ch_b, exp.lanes.ch_a,
                     act.raw, act.lanes.ch_b, act.lanes.ch_a);
            stop_on_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("error %s: expected %b, actual %b", name, exp, act);
            stop_on_failure();
        end
    endtask

    // Lane a is the previous command's low byte over the count byte, lane b its inverse
    function automatic adc_word_u expected_sample(input logic [15:0] cmd, input int count);
        adc_word_u w;
        w.lanes.ch_a = {cmd[7:0], 8'(count)};
        w.lanes.ch_b = ~w.lanes.ch_a;
        return w;
    endfunction

    // ******************************
    // APB tasks
    // ******************************
    // Entered and left 1 ns after a rising edge, results sampled mid access cycle
    task automatic apb_transfer(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                                output apb_data_t rdata, output logic err);
        paddr   = addr;
        pwrite  = write;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge spi_clk);
        #1;
        penable = 1'b1;
        @(negedge spi_clk);
        rdata = prdata;
        err   = pslverr;
        // The slave has no wait states
        check_bit("apb pready", 1'b1, pready);
        @(posedge spi_clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic write_reg(input string name, input apb_addr_t addr, input apb_data_t data);
        apb_data_t rd;
        logic      err;
        apb_transfer(1'b1, addr, data, rd, err);
        check_bit({name, " write pslverr"}, 1'b0, err);
    endtask

    task automatic read_reg(input string name, input apb_addr_t addr, output apb_data_t data);
        logic err;
        apb_transfer(1'b0, addr, '0, data, err);
        check_bit({name, " read pslverr"}, 1'b0, err);
    endtask

    // ******************************
    // Conversion tasks
    // ******************************
    // Polls STATUS until done, irq has to stay low with the interrupt off
    task automatic wait_done(input string name, input int limit);
        apb_data_t st;
        int        n;
        n = 0;
        read_reg(name, ADDR_STATUS, st);
        while (st[STAT_DONE] !== 1'b1) begin
            if (n >= limit) begin
                $display("%s: STATUS done did not set within %0d polls", name, limit);
                stop_on_failure();
            end
            check_bit({name, " irq while polling"}, 1'b0, irq);
            n++;
            read_reg(name, ADDR_STATUS, st);
        end
    endtask

    task automatic wait_irq(input string name, input int limit);
        int n;
        n = 0;
        while (irq !== 1'b1) begin
            if (n >= limit) begin
                $display("%s: irq did not rise within %0d cycles", name, limit);
                stop_on_failure();
            end
            n++;
            @(posedge spi_clk);
            #1;
        end
    endtask

    task automatic start_conversion(input string name, input logic [15:0] cmd,
                                    input logic [CLK_DIV_W-1:0] div, input logic irq_en);
        apb_data_t ctrl_word;
        ctrl_word                            = '0;
        ctrl_word[CTRL_START]                = 1'b1;
        ctrl_word[CTRL_IRQ_EN]               = irq_en;
        ctrl_word[CTRL_DIV_MSB:CTRL_DIV_LSB] = div;
        write_reg(name, ADDR_CMD, {16'h0, cmd});
        write_reg(name, ADDR_CTRL, ctrl_word);
        conv_total++;
    endtask

    task automatic finish_conversion(input string name, input logic [15:0] cmd,
                                     input logic irq_en);
        apb_data_t rd;
        adc_word_u act;
        if (irq_en) begin
            wait_irq(name, 1000);
        end else begin
            wait_done(name, 400);
        end
        check_bit({name, " irq"}, irq_en, irq);
        // Done is set and the engine has gone idle
        read_reg(name, ADDR_STATUS, rd);
        check_word({name, " status"}, 32'h2, rd);
        read_reg(name, ADDR_DATA, rd);
        act.raw = rd;
        check_sample({name, " data"}, expected_sample(prev_cmd, conv_total), act);
        check_word({name, " sdo word"}, {16'h0, cmd}, {16'h0, sdo_word});
        check_word({name, " count"}, apb_data_t'(conv_total), {16'h0, conv_count});
        prev_cmd = cmd;
    endtask

    // Clearing done also drops irq
    task automatic clear_done(input string name);
        apb_data_t rd;
        write_reg(name, ADDR_STATUS, 32'h2);
        check_bit({name, " irq cleared"}, 1'b0, irq);
        read_reg(name, ADDR_STATUS, rd);
        check_word({name, " status cleared"}, 32'h0, rd);
    endtask

    // ******************************
    // Test sequence
    // ******************************
    initial begin : run_tests
        apb_data_t   rd;
        apb_data_t   kept;
        logic        err;
        logic [31:0] rnd;
        string       name;
        int          i;
        int          n;

        paddr      = '0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        pwdata     = '0;
        run_done   = 1'b0;
        run_failed = 1'b0;
        seed       = 32'hc4863885;
        conv_total = 0;
        prev_cmd   = '0;

        n = 0;
        while (arst_n !== 1'b1) begin
            if (n >= 20) begin
                $display("Reset was never released");
                stop_on_failure();
            end
            n++;
            @(posedge spi_clk);
        end
        @(posedge spi_clk);
        #1;

        // Reset state, divider at 1
        check_bit("reset irq", 1'b0, irq);
        check_bit("reset cs", 1'b1, cs);
        read_reg("reset ctrl", ADDR_CTRL, rd);
        check_word("reset ctrl", 32'h0000_0100, rd);
        read_reg("reset cmd", ADDR_CMD, rd);
        check_word("reset cmd", 32'h0, rd);
        read_reg("reset status", ADDR_STATUS, rd);
        check_word("reset status", 32'h0, rd);
        read_reg("reset data", ADDR_DATA, rd);
        check_word("reset data", 32'h0, rd);

        // Polled conversion with the interrupt off
        start_conversion("single", 16'ha5c3, 8'd1, 1'b0);
        finish_conversion("single", 16'ha5c3, 1'b0);
        clear_done("single");

        // Interrupt raised at the end and dropped by the done clear
        start_conversion("interrupt", 16'h5a17, 8'd2, 1'b1);
        finish_conversion("interrupt", 16'h5a17, 1'b1);
        clear_done("interrupt");

        for (i = 0; i < 10; i++) begin
            name = $sformatf("random %0d", i);
            rnd  = $random(seed);
            start_conversion(name, rnd[15:0], {5'd0, rnd[18:16]}, 1'b0);
            finish_conversion(name, rnd[15:0], 1'b0);
            clear_done(name);
        end

        // A second start lands while the engine is busy and is lost
        start_conversion("dropped start", 16'h3c5a, 8'd3, 1'b0);
        read_reg("dropped start", ADDR_STATUS, rd);
        check_bit("dropped start busy", 1'b1, rd[STAT_BUSY]);
        write_reg("dropped start", ADDR_CTRL, 32'h0000_0301);
        finish_conversion("dropped start", 16'h3c5a, 1'b0);
        clear_done("dropped start");

        // Bad accesses flag an error and leave DATA alone
        apb_transfer(1'b0, 4'h2, '0, rd, err);
        check_bit("unmapped read pslverr", 1'b1, err);
        read_reg("data before write", ADDR_DATA, kept);
        rnd = $random(seed);
        apb_transfer(1'b1, ADDR_DATA, rnd, rd, err);
        check_bit("data write pslverr", 1'b1, err);
        read_reg("data after write", ADDR_DATA, rd);
        check_word("data unchanged", kept, rd);
        check_word("final count", apb_data_t'(conv_total), {16'h0, conv_count});

        run_done = 1'b1;
    end

endmodule
